// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       ?= usb_wake_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)

// File: list.f
+incdir+.
usb_wake_pkg.sv
usb_wake_sync.sv
usb_wake_filter.sv
usb_wake_ctrl.sv
usb_wake_pullup_hold.sv
usb_wake_top.sv
usb_wake_assert.sv
usb_wake_tb.sv

// File: usb_wake_assert.sv
`timescale 1ns/1ns
`default_nettype none

// Properties of the detector FSM and its sticky flags
module usb_wake_assert import usb_wake_pkg::*; (
  input wire logic        clk_aon_i,
  input wire logic        rst_aon_ni,
  input wire wake_state_e state_i,
  input wire logic        active_i,
  input wire logic        wake_req_i,
  input wire logic        bus_not_idle_i,
  input wire logic        bus_reset_i,
  input wire logic        sense_lost_i
);

  logic any_flag;

  assign any_flag = bus_not_idle_i | bus_reset_i | sense_lost_i;

  // Flags clear on the first edge spent in idle so they may linger one cycle after the acknowledge
  no_flag_in_idle: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    (state_i == WAKE_IDLE && $past(state_i) == WAKE_IDLE) |-> !(any_flag | wake_req_i))
    else $error("event flag or wake request set while the detector is idle");

  // Every event that sets a flag also raises the wake request in the same cycle
  wake_with_flag: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    any_flag |-> wake_req_i)
    else $error("event flag set without a wake request");

  active_known: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    !$isunknown(active_i))
    else $error("detector active level is unknown");

endmodule

bind usb_wake_ctrl usb_wake_assert u_ctrl_assert (
  .clk_aon_i      (clk_aon_i),
  .rst_aon_ni     (rst_aon_ni),
  .state_i        (state_q),
  .active_i       (active_o),
  .wake_req_i     (wake_req_aon_o),
  .bus_not_idle_i (bus_not_idle_aon_o),
  .bus_reset_i    (bus_reset_aon_o),
  .sense_lost_i   (sense_lost_aon_o)
);

`default_nettype wire

// File: usb_wake_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

// Detector state machine with sticky event flags and the wake request
module usb_wake_ctrl import usb_wake_pkg::*; (
  input  wire logic clk_aon_i,
  input  wire logic rst_aon_ni,
  input  wire logic suspend_req_aon_i,
  input  wire logic wake_ack_aon_i,
  input  wire logic event_not_idle_i,
  input  wire logic event_bus_reset_i,
  input  wire logic event_sense_lost_i,
  output logic      active_o,
  output logic      wake_req_aon_o,
  output logic      bus_not_idle_aon_o,
  output logic      bus_reset_aon_o,
  output logic      sense_lost_aon_o
);

  wake_state_e state_d, state_q;
  logic        active;
  logic        not_idle_q, bus_reset_q, sense_lost_q, wake_req_q;

  // The controller hands over on a suspend request and takes back on acknowledge
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      WAKE_IDLE: begin
        if (suspend_req_aon_i) begin
          state_d = WAKE_ACTIVE;
        end
      end
      WAKE_ACTIVE: begin
        if (wake_ack_aon_i) begin
          state_d = WAKE_IDLE;
        end
      end
    endcase
  end

  assign active = (state_q == WAKE_ACTIVE);

  // Flags collect events only while monitoring and are wiped in idle
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      state_q      <= WAKE_IDLE;
      not_idle_q   <= 1'b0;
      bus_reset_q  <= 1'b0;
      sense_lost_q <= 1'b0;
      wake_req_q   <= 1'b0;
    end else begin
      state_q      <= state_d;
      not_idle_q   <= active & (event_not_idle_i | not_idle_q);
      bus_reset_q  <= active & (event_bus_reset_i | bus_reset_q);
      sense_lost_q <= active & (event_sense_lost_i | sense_lost_q);
      // Any of the three events asks for power-up
      wake_req_q   <= active & (event_not_idle_i | event_bus_reset_i |
                                event_sense_lost_i | wake_req_q);
    end
  end

  assign active_o           = active;
  assign wake_req_aon_o     = wake_req_q;
  assign bus_not_idle_aon_o = not_idle_q;
  assign bus_reset_aon_o    = bus_reset_q;
  assign sense_lost_aon_o   = sense_lost_q;

endmodule

`default_nettype wire

// File: usb_wake_defines.svh
`ifndef USB_WAKE_DEFINES_SVH
`define USB_WAKE_DEFINES_SVH

// Flops in each synchronizer chain that brings pins into the always-on domain
`define USB_WAKE_SYNC_STAGES 2

// Consecutive samples needed before line activity counts as an event
// At an always-on clock near 200 kHz this is about 20 us of activity
// It also gives the main controller time to see resume if it stayed awake
`define USB_WAKE_ACTIVITY_CYCLES 4

// Consecutive samples needed before SE0 or loss of VBUS sense counts
`define USB_WAKE_EVENT_CYCLES 3

`endif

// File: usb_wake_filter.sv
`timescale 1ns/1ns
`default_nettype none

`include "usb_wake_defines.svh"

// Debounce filter for one synchronized condition
module usb_wake_filter #(
  parameter int unsigned cycles = `USB_WAKE_EVENT_CYCLES
) (
  input  wire logic clk_aon_i,
  input  wire logic rst_aon_ni,
  input  wire logic filter_i,
  output logic      filter_o
);

  // The counter saturates at cycles so it needs room for that value
  localparam int unsigned cnt_w = $clog2(cycles + 1);

  logic             prev_q;
  logic [cnt_w-1:0] count_d, count_q;
  logic             out_q;

  // Count consecutive samples that agree with the previous one
  // A change of the input starts the run again at one sample
  always_comb begin
    if (filter_i != prev_q) begin
      count_d = cnt_w'(1);
    end else if (count_q < cnt_w'(cycles)) begin
      count_d = count_q + cnt_w'(1);
    end else begin
      count_d = count_q;
    end
  end

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      prev_q  <= 1'b0;
      count_q <= '0;
      out_q   <= 1'b0;
    end else begin
      prev_q  <= filter_i;
      count_q <= count_d;
      // The output moves only on the edge that completes a full run
      if (count_d == cnt_w'(cycles)) begin
        out_q <= filter_i;
      end
    end
  end

  assign filter_o = out_q;

endmodule

`default_nettype wire

// File: usb_wake_pkg.sv
`default_nettype none

package usb_wake_pkg;

  // Detector state
  // In idle the controller owns the pull-ups, in active the detector holds them
  typedef enum logic [0:0] {
    WAKE_IDLE   = 1'b0,
    WAKE_ACTIVE = 1'b1
  } wake_state_e;

  // One sample of the bus pins and the VBUS sense input
  typedef struct packed {
    logic dp;
    logic dn;
    logic sense;
  } line_sample_t;

  // D+ and D- pull-up enables as one pair
  typedef struct packed {
    logic dp;
    logic dn;
  } pullup_pair_t;

endpackage

`default_nettype wire

// File: usb_wake_pullup_hold.sv
`timescale 1ns/1ns
`default_nettype none

// Pull-up enables for the pins, passed through or held during suspend
module usb_wake_pullup_hold import usb_wake_pkg::*; (
  input  wire logic         clk_aon_i,
  input  wire logic         rst_aon_ni,
  input  wire logic         active_i,
  input  wire pullup_pair_t pullup_en_i,
  input  wire pullup_pair_t pullup_en_sync_i,
  output pullup_pair_t      pullup_en_o
);

  // Last synchronized pair seen before the detector took over
  pullup_pair_t held_q;

  // Track the controller while idle and freeze once active
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      held_q <= '0;
    end else if (!active_i) begin
      held_q <= pullup_en_sync_i;
    end
  end

  // While idle the pins see the controller without any added latency
  // The held copy keeps the device attached once the controller sleeps
  always_comb begin
    if (active_i) begin
      pullup_en_o = held_q;
    end else begin
      pullup_en_o = pullup_en_i;
    end
  end

endmodule

`default_nettype wire

// File: usb_wake_sync.sv
`timescale 1ns/1ns
`default_nettype none

`include "usb_wake_defines.svh"

// Flop chain that brings an asynchronous payload into the always-on domain
module usb_wake_sync #(
  parameter type payload_t = logic,
  parameter int unsigned stages = `USB_WAKE_SYNC_STAGES
) (
  input  wire logic     clk_aon_i,
  input  wire logic     rst_aon_ni,
  input  wire payload_t d_i,
  output payload_t      q_o
);

  // Stage 0 samples the pin, the last stage is the safe copy
  payload_t stage_q [stages];

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      for (int i = 0; i < stages; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      // Each later stage takes the value of the one before it
      for (int i = 1; i < stages; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[stages-1];

endmodule

`default_nettype wire

// File: usb_wake_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "usb_wake_defines.svh"

module usb_wake_tb;

  localparam int CLK_PERIOD = 4;
  localparam int ACT_LEN    = `USB_WAKE_ACTIVITY_CYCLES;
  localparam int EVT_LEN    = `USB_WAKE_EVENT_CYCLES;
  // Worst pin-to-flag latency plus a margin of 12 cycles
  localparam int SETTLE     = `USB_WAKE_SYNC_STAGES + ACT_LEN + 2 + 12;
  localparam int MAX_HOLD   = ACT_LEN + 4;
  localparam int NUM_TESTS  = 6;
  // A test makes at most a dozen holds or settle waits
  localparam int WATCHDOG_NS = NUM_TESTS * 12 * (MAX_HOLD + SETTLE + 4) * CLK_PERIOD;
  // Bus conditions that the stimulus can hold
  localparam int COND_J = 0, COND_K = 1, COND_SE0 = 2, COND_SENSE_LOW = 3;

  logic       clk_aon = 1'b0;
  logic       rst_aon_n;
  logic       usb_dp, usb_dn, usb_sense, ctrl_dp_en, ctrl_dn_en, wake_ack, suspend_req;
  logic       pin_dp_en, pin_dn_en, wake_req, bus_not_idle, bus_reset, sense_lost;
  logic       detect_active;
  int         seed = 32'hde17bcad;

  // Model of the detector, kept by the stimulus
  logic       model_active, held_dp, held_dn;
  int         cond_q[$];
  int         len_q[$];
  logic [3:0] exp_flags;
  string      test_name;
  int         tests_run, check_count, error_count, errors_at_start;
  event       check_req, check_done;

  usb_wake_top dut_i (
    .clk_aon_i                (clk_aon),
    .rst_aon_ni               (rst_aon_n),
    .usb_dp_i                 (usb_dp),
    .usb_dn_i                 (usb_dn),
    .usb_sense_i              (usb_sense),
    .usbdev_dppullup_en_i     (ctrl_dp_en),
    .usbdev_dnpullup_en_i     (ctrl_dn_en),
    .wake_ack_aon_i           (wake_ack),
    .suspend_req_aon_i        (suspend_req),
    .usb_dppullup_en_o        (pin_dp_en),
    .usb_dnpullup_en_o        (pin_dn_en),
    .wake_req_aon_o           (wake_req),
    .bus_not_idle_aon_o       (bus_not_idle),
    .bus_reset_aon_o          (bus_reset),
    .sense_lost_aon_o         (sense_lost),
    .wake_detect_active_aon_o (detect_active)
  );

  always #(CLK_PERIOD / 2) clk_aon = ~clk_aon;

  function automatic int random_range(input int lo, input int hi);
    int unsigned r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  // Expected {wake_req, bus_not_idle, bus_reset, sense_lost} from the holds since entry
  // Every hold ends in J, so each one is judged on its own length
  // SE0 differs from the held J on D+, so a long SE0 also counts as activity
  function automatic logic [3:0] expected_flags(input logic act);
    logic not_idle, reset_seen, sense_seen;
    not_idle   = 1'b0;
    reset_seen = 1'b0;
    sense_seen = 1'b0;
    for (int i = 0; i < cond_q.size(); i++) begin
      if (act && (cond_q[i] == COND_K || cond_q[i] == COND_SE0) && len_q[i] >= ACT_LEN) begin
        not_idle = 1'b1;
      end
      if (act && cond_q[i] == COND_SE0 && len_q[i] >= EVT_LEN) begin
        reset_seen = 1'b1;
      end
      if (act && cond_q[i] == COND_SENSE_LOW && len_q[i] >= EVT_LEN) begin
        sense_seen = 1'b1;
      end
    end
    return {not_idle | reset_seen | sense_seen, not_idle, reset_seen, sense_seen};
  endfunction

  task automatic compare_bit(input string sig, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s %s: expected %0b, actual %0b", test_name, sig, expected, actual);
    end
  endtask

  // Compares every output against the model when the stimulus asks for it
  always begin
    @(check_req);
    exp_flags = expected_flags(model_active);
    compare_bit("wake_detect_active", model_active, detect_active);
    compare_bit("wake_req", exp_flags[3], wake_req);
    compare_bit("bus_not_idle", exp_flags[2], bus_not_idle);
    compare_bit("bus_reset", exp_flags[1], bus_reset);
    compare_bit("sense_lost", exp_flags[0], sense_lost);
    compare_bit("dppullup_en", model_active ? held_dp : ctrl_dp_en, pin_dp_en);
    compare_bit("dnpullup_en", model_active ? held_dn : ctrl_dn_en, pin_dn_en);
    -> check_done;
  end

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk_aon);
    #1;
  endtask

  task automatic check_now();
    #2;
    -> check_req;
    @(check_done);
  endtask

  task automatic settle_and_check();
    repeat (SETTLE) step();
    check_now();
  endtask

  task automatic drive_line(input int cond);
    usb_dp    = (cond == COND_J) || (cond == COND_SENSE_LOW);
    usb_dn    = (cond == COND_K);
    usb_sense = (cond != COND_SENSE_LOW);
  endtask

  // Holds a bus condition for len samples and then returns the bus to J
  task automatic hold_condition(input int cond, input int len);
    step();
    drive_line(cond);
    repeat (len) step();
    drive_line(COND_J);
    cond_q.push_back(cond);
    len_q.push_back(len);
  endtask

  task automatic set_controller_pullups(input logic dp, input logic dn);
    step();
    ctrl_dp_en = dp;
    ctrl_dn_en = dn;
  endtask

  // The pins keep the pair that the controller drove before the request
  task automatic enter_suspend();
    step();
    suspend_req = 1'b1;
    step();
    suspend_req = 1'b0;
    model_active = 1'b1;
    held_dp = ctrl_dp_en;
    held_dn = ctrl_dn_en;
    cond_q.delete();
    len_q.delete();
  endtask

  task automatic acknowledge();
    step();
    wake_ack = 1'b1;
    step();
    wake_ack = 1'b0;
    model_active = 1'b0;
    cond_q.delete();
    len_q.delete();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = error_count;
    tests_run++;
  endtask

  task automatic finish_test();
    if (error_count == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, test_name, error_count - errors_at_start);
    end
  endtask

  initial begin
    int kind;
    model_active = 1'b0;
    tests_run    = 0;
    check_count  = 0;
    error_count  = 0;
    rst_aon_n    = 1'b0;
    wake_ack     = 1'b0;
    suspend_req  = 1'b0;
    ctrl_dp_en   = 1'b1;
    ctrl_dn_en   = 1'b0;
    drive_line(COND_J);
    repeat (3) @(posedge clk_aon);
    #1;
    rst_aon_n = 1'b1;

    start_test("reset_and_passthrough");
    settle_and_check();
    repeat (4) begin
      set_controller_pullups(1'(random_range(0, 1)), 1'(random_range(0, 1)));
      check_now();
    end
    set_controller_pullups(1'b1, 1'b0);
    settle_and_check();
    finish_test();

    start_test("suspend_entry_hold");
    enter_suspend();
    check_now();
    repeat (4) begin
      set_controller_pullups(1'(random_range(0, 1)), 1'(random_range(0, 1)));
      check_now();
    end
    set_controller_pullups(1'b1, 1'b0);
    settle_and_check();
    finish_test();

    // Short glitches of random kind and length come first and must be ignored
    start_test("resume_k_and_glitches");
    repeat (random_range(3, 5)) begin
      kind = random_range(COND_K, COND_SENSE_LOW);
      hold_condition(kind, random_range(1, (kind == COND_K ? ACT_LEN : EVT_LEN) - 1));
    end
    settle_and_check();
    hold_condition(COND_K, random_range(ACT_LEN, MAX_HOLD));
    settle_and_check();
    finish_test();

    start_test("bus_reset_se0");
    acknowledge();
    settle_and_check();
    enter_suspend();
    hold_condition(COND_SE0, random_range(ACT_LEN, MAX_HOLD));
    settle_and_check();
    finish_test();

    start_test("sense_lost");
    acknowledge();
    settle_and_check();
    enter_suspend();
    hold_condition(COND_SENSE_LOW, random_range(EVT_LEN, MAX_HOLD));
    settle_and_check();
    // Bus is back at J and the flags must still hold
    settle_and_check();
    finish_test();

    start_test("wake_ack_release");
    acknowledge();
    settle_and_check();
    repeat (4) begin
      set_controller_pullups(1'(random_range(0, 1)), 1'(random_range(0, 1)));
      check_now();
    end
    finish_test();

    $display("%0d tests run, %0d checks, %0d errors", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: usb_wake_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "usb_wake_defines.svh"

// Always-on USB wake detector
module usb_wake_top import usb_wake_pkg::*; (
  input  wire logic clk_aon_i,
  input  wire logic rst_aon_ni,
  // Bus pins and VBUS sense
  input  wire logic usb_dp_i,
  input  wire logic usb_dn_i,
  input  wire logic usb_sense_i,
  // Pull-up enables from the main controller
  input  wire logic usbdev_dppullup_en_i,
  input  wire logic usbdev_dnpullup_en_i,
  // Strobes from the controller, already in the always-on domain
  input  wire logic wake_ack_aon_i,
  input  wire logic suspend_req_aon_i,
  // Pull-up enables kept alive through low power
  output logic      usb_dppullup_en_o,
  output logic      usb_dnpullup_en_o,
  output logic      wake_req_aon_o,
  output logic      bus_not_idle_aon_o,
  output logic      bus_reset_aon_o,
  output logic      sense_lost_aon_o,
  output logic      wake_detect_active_aon_o
);

  line_sample_t line_raw, line_sync;
  pullup_pair_t pullup_raw, pullup_sync, pullup_out;
  logic         active;
  logic         not_idle_raw, se0_raw, sense_lost_raw;
  logic         event_not_idle, event_bus_reset, event_sense_lost;

  assign line_raw.dp    = usb_dp_i;
  assign line_raw.dn    = usb_dn_i;
  assign line_raw.sense = usb_sense_i;
  assign pullup_raw.dp  = usbdev_dppullup_en_i;
  assign pullup_raw.dn  = usbdev_dnpullup_en_i;

  usb_wake_sync #(.payload_t(line_sample_t)) u_line_sync (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .d_i        (line_raw),
    .q_o        (line_sync)
  );

  usb_wake_sync #(.payload_t(pullup_pair_t)) u_pullup_sync (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .d_i        (pullup_raw),
    .q_o        (pullup_sync)
  );

  // In suspend the device pull-ups set the line, so any difference is the host
  // That catches resume (K) and reset (SE0) and also copes with swapped pins
  assign not_idle_raw   = (line_sync.dp != pullup_out.dp) | (line_sync.dn != pullup_out.dn);
  assign se0_raw        = ~line_sync.dp & ~line_sync.dn;
  assign sense_lost_raw = ~line_sync.sense;

  usb_wake_filter #(.cycles(`USB_WAKE_ACTIVITY_CYCLES)) u_filter_activity (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (not_idle_raw),
    .filter_o   (event_not_idle)
  );

  usb_wake_filter #(.cycles(`USB_WAKE_EVENT_CYCLES)) u_filter_bus_reset (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (se0_raw),
    .filter_o   (event_bus_reset)
  );

  usb_wake_filter #(.cycles(`USB_WAKE_EVENT_CYCLES)) u_filter_sense (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (sense_lost_raw),
    .filter_o   (event_sense_lost)
  );

  usb_wake_ctrl u_ctrl (
    .clk_aon_i          (clk_aon_i),
    .rst_aon_ni         (rst_aon_ni),
    .suspend_req_aon_i  (suspend_req_aon_i),
    .wake_ack_aon_i     (wake_ack_aon_i),
    .event_not_idle_i   (event_not_idle),
    .event_bus_reset_i  (event_bus_reset),
    .event_sense_lost_i (event_sense_lost),
    .active_o           (active),
    .wake_req_aon_o     (wake_req_aon_o),
    .bus_not_idle_aon_o (bus_not_idle_aon_o),
    .bus_reset_aon_o    (bus_reset_aon_o),
    .sense_lost_aon_o   (sense_lost_aon_o)
  );

  usb_wake_pullup_hold u_pullup_hold (
    .clk_aon_i        (clk_aon_i),
    .rst_aon_ni       (rst_aon_ni),
    .active_i         (active),
    .pullup_en_i      (pullup_raw),
    .pullup_en_sync_i (pullup_sync),
    .pullup_en_o      (pullup_out)
  );

  assign usb_dppullup_en_o        = pullup_out.dp;
  assign usb_dnpullup_en_o        = pullup_out.dn;
  assign wake_detect_active_aon_o = active;

endmodule

`default_nettype wire
